/* logic/soc_pkg.sv */
package soc_pkg;

    // address map, word addressed
    localparam int ADDR_GPIO_BIT = 7;
    localparam int RAM_WORDS     = 128;

    // gpio register offsets within the low seven address bits
    localparam logic [6:0] GPIO_OUT_OFS = 7'd0;
    localparam logic [6:0] GPIO_SET_OFS = 7'd1;
    localparam logic [6:0] GPIO_CLR_OFS = 7'd2;

    // shifted out when a read ends in error
    localparam logic [31:0] ERR_RDATA = 32'hffff_ffff;

    typedef enum logic [7:0] {
        op_write = 8'h02,
        op_read  = 8'h03
    } spi_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_cmd,
        st_addr,
        st_wdata,
        st_bus,
        st_rdata,
        st_skip
    } spi_state_e;

    // host to device
    typedef struct packed {
        logic        a_valid;
        logic        a_write;
        logic [7:0]  a_addr;
        logic [31:0] a_wdata;
    } bus_req_t;

    // device to host
    typedef struct packed {
        logic        a_ready;
        logic        d_valid;
        logic        d_error;
        logic [31:0] d_rdata;
    } bus_rsp_t;

endpackage

/* logic/spi_bus_host.sv */
`timescale 1ns/1ps

module spi_bus_host (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              spi_sclk_i,
    input  logic              spi_cs_i,
    input  logic              spi_sdi0_i,
    output logic              spi_sdo0_o,
    output soc_pkg::bus_req_t bus_req_o,
    input  soc_pkg::bus_rsp_t bus_rsp_i
);

    // synchronizer bit order is {sclk, cs, sdi}
    logic [2:0]  sync1_q;
    logic [2:0]  sync2_q;
    logic        sclk_d_q;
    logic        sclk_s;
    logic        cs_s;
    logic        sdi_s;
    logic        sclk_rise;
    logic        sclk_fall;
    logic        last_byte;
    logic        last_word;

    soc_pkg::spi_state_e state_q;
    soc_pkg::spi_op_e    op_q;
    logic [4:0]          bit_cnt_q;
    logic [31:0]         rx_q;
    logic [31:0]         rx_next;
    logic [31:0]         tx_q;
    logic                sdo_q;
    logic                req_valid_q;
    logic [7:0]          addr_q;
    logic [31:0]         wdata_q;
    logic                xfer;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // cs idles high
            sync1_q  <= 3'b010;
            sync2_q  <= 3'b010;
            sclk_d_q <= 1'b0;
        end else begin
            sync1_q  <= {spi_sclk_i, spi_cs_i, spi_sdi0_i};
            sync2_q  <= sync1_q;
            sclk_d_q <= sync2_q[2];
        end
    end

    assign sclk_s    = sync2_q[2];
    assign cs_s      = sync2_q[1];
    assign sdi_s     = sync2_q[0];
    assign sclk_rise = sclk_s && !sclk_d_q;
    assign sclk_fall = !sclk_s && sclk_d_q;
    assign rx_next   = {rx_q[30:0], sdi_s};
    assign last_byte = sclk_rise && (bit_cnt_q == 5'd7);
    assign last_word = sclk_rise && (bit_cnt_q == 5'd31);
    assign xfer      = req_valid_q && bus_rsp_i.a_ready;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= soc_pkg::st_idle;
            bit_cnt_q   <= '0;
            req_valid_q <= 1'b0;
            sdo_q       <= 1'b0;
        end else begin
            if (xfer) begin
                req_valid_q <= 1'b0;
            end
            case (state_q)
                soc_pkg::st_idle: begin
                    if (!cs_s) begin
                        state_q   <= soc_pkg::st_cmd;
                        bit_cnt_q <= '0;
                    end
                end
                soc_pkg::st_cmd: begin
                    if (sclk_rise) begin
                        bit_cnt_q <= bit_cnt_q + 5'd1;
                    end
                    if (last_byte) begin
                        bit_cnt_q <= '0;
                        if (rx_next[7:0] == soc_pkg::op_write ||
                            rx_next[7:0] == soc_pkg::op_read) begin
                            state_q <= soc_pkg::st_addr;
                        end else begin
                            state_q <= soc_pkg::st_skip;
                        end
                    end
                end
                soc_pkg::st_addr: begin
                    if (sclk_rise) begin
                        bit_cnt_q <= bit_cnt_q + 5'd1;
                    end
                    if (last_byte) begin
                        bit_cnt_q <= '0;
                        if (op_q == soc_pkg::op_write) begin
                            state_q <= soc_pkg::st_wdata;
                        end else begin
                            state_q     <= soc_pkg::st_bus;
                            req_valid_q <= 1'b1;
                        end
                    end
                end
                soc_pkg::st_wdata: begin
                    if (sclk_rise) begin
                        bit_cnt_q <= bit_cnt_q + 5'd1;
                    end
                    if (last_word) begin
                        bit_cnt_q   <= '0;
                        state_q     <= soc_pkg::st_bus;
                        req_valid_q <= 1'b1;
                    end
                end
                soc_pkg::st_bus: begin
                    if (bus_rsp_i.d_valid) begin
                        bit_cnt_q <= '0;
                        if (op_q == soc_pkg::op_read) begin
                            state_q <= soc_pkg::st_rdata;
                        end else begin
                            state_q <= soc_pkg::st_skip;
                        end
                    end
                end
                soc_pkg::st_rdata: begin
                    if (sclk_fall) begin
                        sdo_q     <= tx_q[31];
                        bit_cnt_q <= bit_cnt_q + 5'd1;
                        if (bit_cnt_q == 5'd31) begin
                            state_q <= soc_pkg::st_skip;
                        end
                    end
                end
                soc_pkg::st_skip: begin
                    bit_cnt_q <= '0;
                end
                default: begin
                    state_q <= soc_pkg::st_idle;
                end
            endcase
            // cs high ends the frame, but a request in flight must complete
            if (cs_s && state_q != soc_pkg::st_bus) begin
                state_q     <= soc_pkg::st_idle;
                req_valid_q <= 1'b0;
                sdo_q       <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sclk_rise) begin
            rx_q <= rx_next;
        end
        if (state_q == soc_pkg::st_cmd && last_byte) begin
            op_q <= soc_pkg::spi_op_e'(rx_next[7:0]);
        end
        if (state_q == soc_pkg::st_addr && last_byte) begin
            addr_q  <= rx_next[7:0];
            wdata_q <= '0;
        end
        if (state_q == soc_pkg::st_wdata && last_word) begin
            wdata_q <= rx_next;
        end
        // load read data, msb goes out first
        if (state_q == soc_pkg::st_bus && bus_rsp_i.d_valid) begin
            tx_q <= bus_rsp_i.d_error ? soc_pkg::ERR_RDATA : bus_rsp_i.d_rdata;
        end else if (state_q == soc_pkg::st_rdata && sclk_fall) begin
            tx_q <= {tx_q[30:0], 1'b0};
        end
    end

    always_comb begin
        bus_req_o.a_valid = req_valid_q;
        bus_req_o.a_write = (op_q == soc_pkg::op_write);
        bus_req_o.a_addr  = addr_q;
        bus_req_o.a_wdata = wdata_q;
    end

    assign spi_sdo0_o = sdo_q;

    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        bus_req_o.a_valid && !bus_rsp_i.a_ready |=> $stable(bus_req_o))
        else $error("request changed before acceptance");

    a_no_rsp_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        bus_rsp_i.d_valid |-> state_q != soc_pkg::st_idle)
        else $error("response while host in %s", state_q.name());

endmodule

/* logic/bus_xbar.sv */
`timescale 1ns/1ps

module bus_xbar (
    input  logic              clk_i,
    input  logic              reset_i,
    input  soc_pkg::bus_req_t host_req_i,
    output soc_pkg::bus_rsp_t host_rsp_o,
    output soc_pkg::bus_req_t ram_req_o,
    input  soc_pkg::bus_rsp_t ram_rsp_i,
    output soc_pkg::bus_req_t gpio_req_o,
    input  soc_pkg::bus_rsp_t gpio_rsp_i
);

    logic              sel_gpio;
    logic              dev_ready;
    logic              xfer;
    logic              busy_q;
    logic              busy_next;
    logic              ready_q;
    logic              sel_gpio_q;
    soc_pkg::bus_rsp_t dev_rsp;
    logic              rsp_valid_q;
    logic              rsp_error_q;
    logic [31:0]       rsp_rdata_q;

    assign sel_gpio  = host_req_i.a_addr[soc_pkg::ADDR_GPIO_BIT];
    assign dev_ready = sel_gpio ? gpio_rsp_i.a_ready : ram_rsp_i.a_ready;
    assign xfer      = host_req_i.a_valid && ready_q && dev_ready;
    // response comes from the device that took the request
    assign dev_rsp   = sel_gpio_q ? gpio_rsp_i : ram_rsp_i;

    always_comb begin
        ram_req_o          = host_req_i;
        ram_req_o.a_valid  = host_req_i.a_valid && ready_q && !sel_gpio;
        gpio_req_o         = host_req_i;
        gpio_req_o.a_valid = host_req_i.a_valid && ready_q && sel_gpio;
    end

    always_comb begin
        busy_next = busy_q;
        if (dev_rsp.d_valid) begin
            busy_next = 1'b0;
        end
        if (xfer) begin
            busy_next = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            ready_q     <= 1'b0;
            sel_gpio_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            busy_q      <= busy_next;
            ready_q     <= !busy_next;
            rsp_valid_q <= dev_rsp.d_valid;
            if (xfer) begin
                sel_gpio_q <= sel_gpio;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dev_rsp.d_valid) begin
            rsp_error_q <= dev_rsp.d_error;
            rsp_rdata_q <= dev_rsp.d_rdata;
        end
    end

    always_comb begin
        host_rsp_o.a_ready = ready_q && dev_ready;
        host_rsp_o.d_valid = rsp_valid_q;
        host_rsp_o.d_error = rsp_error_q;
        host_rsp_o.d_rdata = rsp_rdata_q;
    end

    // only one device holds a request at a time
    a_one_target: assert property (@(posedge clk_i) disable iff (reset_i)
        (ram_req_o.a_valid || gpio_req_o.a_valid) |-> !busy_q)
        else $error("device request while another one is outstanding");

    a_rsp_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
        (ram_rsp_i.d_valid || gpio_rsp_i.d_valid) |-> busy_q)
        else $error("device response without outstanding request");

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic              clk_i,
    input  logic              reset_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    logic [31:0]                         mem_q [soc_pkg::RAM_WORDS];
    logic [soc_pkg::ADDR_GPIO_BIT-1:0]   idx;
    logic [31:0]                         rdata_q;
    logic                                valid_q;

    assign idx = req_i.a_addr[soc_pkg::ADDR_GPIO_BIT-1:0];

    always_ff @(posedge clk_i) begin
        if (req_i.a_valid) begin
            if (req_i.a_write) begin
                mem_q[idx] <= req_i.a_wdata;
                rdata_q    <= '0;
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    // one response per request, next cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.a_valid;
        end
    end

    always_comb begin
        rsp_o.a_ready = 1'b1;
        rsp_o.d_valid = valid_q;
        rsp_o.d_error = 1'b0;
        rsp_o.d_rdata = rdata_q;
    end

endmodule

/* logic/gpio_device.sv */
`timescale 1ns/1ps

module gpio_device (
    input  logic              clk_i,
    input  logic              reset_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o,
    output logic [31:0]       gpio_o
);

    logic [soc_pkg::ADDR_GPIO_BIT-1:0] ofs;
    logic                              ofs_ok;
    logic [31:0]                       gpio_q;
    logic                              valid_q;
    logic                              error_q;
    logic [31:0]                       rdata_q;

    assign ofs    = req_i.a_addr[soc_pkg::ADDR_GPIO_BIT-1:0];
    assign ofs_ok = (ofs == soc_pkg::GPIO_OUT_OFS) || (ofs == soc_pkg::GPIO_SET_OFS) ||
                    (ofs == soc_pkg::GPIO_CLR_OFS);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gpio_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.a_valid;
            if (req_i.a_valid && req_i.a_write) begin
                case (ofs)
                    soc_pkg::GPIO_OUT_OFS: gpio_q <= req_i.a_wdata;
                    soc_pkg::GPIO_SET_OFS: gpio_q <= gpio_q | req_i.a_wdata;
                    soc_pkg::GPIO_CLR_OFS: gpio_q <= gpio_q & ~req_i.a_wdata;
                    // unmapped offset leaves the register alone
                    default: gpio_q <= gpio_q;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.a_valid) begin
            error_q <= !ofs_ok;
            rdata_q <= (ofs_ok && !req_i.a_write) ? gpio_q : '0;
        end
    end

    always_comb begin
        rsp_o.a_ready = 1'b1;
        rsp_o.d_valid = valid_q;
        rsp_o.d_error = error_q;
        rsp_o.d_rdata = rdata_q;
    end

    assign gpio_o = gpio_q;

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        spi_sclk_i,
    input  logic        spi_cs_i,
    input  logic        spi_sdi0_i,
    output logic        spi_sdo0_o,
    output logic [31:0] gpio_o
);

    soc_pkg::bus_req_t host_2_xbar;
    soc_pkg::bus_rsp_t xbar_2_host;
    soc_pkg::bus_req_t xbar_2_ram;
    soc_pkg::bus_rsp_t ram_2_xbar;
    soc_pkg::bus_req_t xbar_2_gpio;
    soc_pkg::bus_rsp_t gpio_2_xbar;

    // single-lane spi host
    spi_bus_host u_spi_bus_host (
        .clk_i      (clk_i       ),
        .reset_i    (reset_i     ),
        .spi_sclk_i (spi_sclk_i  ),
        .spi_cs_i   (spi_cs_i    ),
        .spi_sdi0_i (spi_sdi0_i  ),
        .spi_sdo0_o (spi_sdo0_o  ),
        .bus_req_o  (host_2_xbar ),
        .bus_rsp_i  (xbar_2_host )
    );

    // 1 host, 2 devices
    bus_xbar u_bus_xbar (
        .clk_i      (clk_i       ),
        .reset_i    (reset_i     ),
        .host_req_i (host_2_xbar ),
        .host_rsp_o (xbar_2_host ),
        .ram_req_o  (xbar_2_ram  ),
        .ram_rsp_i  (ram_2_xbar  ),
        .gpio_req_o (xbar_2_gpio ),
        .gpio_rsp_i (gpio_2_xbar )
    );

    data_ram u_data_ram (
        .clk_i      (clk_i       ),
        .reset_i    (reset_i     ),
        .req_i      (xbar_2_ram  ),
        .rsp_o      (ram_2_xbar  )
    );

    gpio_device u_gpio_device (
        .clk_i      (clk_i       ),
        .reset_i    (reset_i     ),
        .req_i      (xbar_2_gpio ),
        .rsp_o      (gpio_2_xbar ),
        .gpio_o     (gpio_o      )
    );

endmodule

/* tests/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb;

    logic        clk_i;
    logic        reset_i;
    logic        spi_sclk_i;
    logic        spi_cs_i;
    logic        spi_sdi0_i;
    logic        spi_sdo0_o;
    logic [31:0] gpio_o;

    // reference model
    logic [31:0] ram_model [soc_pkg::RAM_WORDS];
    logic [31:0] gpio_model;

    logic [7:0]  addrs [16];
    logic [31:0] rd;
    logic [31:0] wd;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;

    soc_top dut_i (
        .clk_i      (clk_i      ),
        .reset_i    (reset_i    ),
        .spi_sclk_i (spi_sclk_i ),
        .spi_cs_i   (spi_cs_i   ),
        .spi_sdi0_i (spi_sdi0_i ),
        .spi_sdo0_o (spi_sdo0_o ),
        .gpio_o     (gpio_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("Error %s expected %h got %h", name, exp, got);
            test_errs++;
        end
    endtask

    task automatic wait_host_idle();
        int cycles;
        cycles = 0;
        while (dut_i.u_spi_bus_host.state_q != soc_pkg::st_idle && cycles < 200) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (dut_i.u_spi_bus_host.state_q == soc_pkg::st_idle) else begin
            $display("wait for the SPI host to go idle timed out in state %s",
                     dut_i.u_spi_bus_host.state_q.name());
            test_errs++;
        end
    endtask

    task automatic wait_gpio(input logic [31:0] exp);
        int cycles;
        cycles = 0;
        while (gpio_o !== exp && cycles < 200) begin
            @(negedge clk_i);
            cycles++;
        end
        if (cycles >= 200) begin
            $display("wait for gpio_o to settle timed out");
        end
        check_value("gpio_o", exp, gpio_o);
    endtask

    // mode 0, msb first, 8 clk cycles per sclk phase
    task automatic spi_frame(input logic [7:0] op, input logic [7:0] addr,
                             input logic [31:0] data, input int nbits,
                             output logic [31:0] rdata);
        logic [47:0] word;
        word  = {op, addr, data};
        rdata = '0;
        @(negedge clk_i);
        spi_cs_i = 1'b0;
        repeat (8) @(negedge clk_i);
        for (int i = 0; i < nbits; i++) begin
            spi_sdi0_i = word[47-i];
            repeat (8) @(negedge clk_i);
            // read data is shifted out after the address byte
            if (i >= 16) begin
                rdata = {rdata[30:0], spi_sdo0_o};
            end
            spi_sclk_i = 1'b1;
            repeat (8) @(negedge clk_i);
            spi_sclk_i = 1'b0;
        end
        repeat (8) @(negedge clk_i);
        spi_cs_i   = 1'b1;
        spi_sdi0_i = 1'b0;
        wait_host_idle();
    endtask

    task automatic write_word(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        spi_frame(soc_pkg::op_write, addr, data, 48, unused);
    endtask

    task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
        spi_frame(soc_pkg::op_read, addr, 32'h0, 48, data);
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    initial begin
        reset_i    = 1'b1;
        spi_sclk_i = 1'b0;
        spi_cs_i   = 1'b1;
        spi_sdi0_i = 1'b0;
        test_errs  = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        gpio_model = '0;
        void'($urandom(32'h21b4));
        repeat (10) @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);

        check_value("gpio_o", 32'h0, gpio_o);
        check_value("spi_sdo0_o", 32'h0, {31'h0, spi_sdo0_o});
        finish_test("reset values");

        for (int i = 0; i < 16; i++) begin
            addrs[i] = 8'($urandom % soc_pkg::RAM_WORDS);
            wd       = $urandom;
            write_word(addrs[i], wd);
            ram_model[addrs[i][6:0]] = wd;
        end
        for (int i = 0; i < 16; i++) begin
            read_word(addrs[i], rd);
            check_value("spi_sdo0_o", ram_model[addrs[i][6:0]], rd);
        end
        finish_test("ram write and read");

        wd = $urandom;
        write_word(8'h80, wd);
        gpio_model = wd;
        wait_gpio(gpio_model);
        wd = $urandom;
        write_word(8'h81, wd);
        gpio_model = gpio_model | wd;
        wait_gpio(gpio_model);
        wd = $urandom;
        write_word(8'h82, wd);
        gpio_model = gpio_model & ~wd;
        wait_gpio(gpio_model);
        read_word(8'h80, rd);
        check_value("spi_sdo0_o", gpio_model, rd);
        finish_test("gpio write, set and clear");

        read_word(8'h85, rd);
        check_value("spi_sdo0_o", soc_pkg::ERR_RDATA, rd);
        write_word(8'h85, ~gpio_model);
        wait_gpio(gpio_model);
        read_word(8'h80, rd);
        check_value("spi_sdo0_o", gpio_model, rd);
        finish_test("gpio unmapped offset");

        // bad opcode to gpio, then a write to ram cut short
        spi_frame(8'h5a, 8'h80, ~gpio_model, 48, rd);
        spi_frame(soc_pkg::op_write, addrs[0], ~ram_model[addrs[0][6:0]], 20, rd);
        wait_gpio(gpio_model);
        read_word(addrs[0], rd);
        check_value("spi_sdo0_o", ram_model[addrs[0][6:0]], rd);
        read_word(8'h80, rd);
        check_value("spi_sdo0_o", gpio_model, rd);
        finish_test("unknown opcode and aborted frame");

        $display("summary: %0d passed, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/soc_pkg.sv
logic/spi_bus_host.sv
logic/bus_xbar.sv
logic/data_ram.sv
logic/gpio_device.sv
logic/soc_top.sv
tests/soc_tb.sv
